/* Bender.yml */
package:
  name: rv_core_pipeline

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/rv_core_pkg.sv
      - design/fetch_stage.sv
      - design/register_file.sv
      - design/decode_stage.sv
      - design/execute_stage.sv
      - design/cpu_pipeline.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/cpu_pipeline_props.sv
      - testbench/tb_cpu_pipeline.sv

/* design/cpu_pipeline.sv */
////////////////////////////////////////////////////////////
// three-stage RV32I pipeline top level
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module cpu_pipeline import rv_core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output logic [`XLEN-1:0]   inst_addr,
    input  logic [`INST_W-1:0] inst_data,
    output wb_t                wb
);

    if_id_t                 if_id;
    id_ex_t                 id_ex;
    wb_t                    ex_fwd;
    redirect_t              redirect;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    fetch_stage fetch_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .inst_data (inst_data),
        .inst_addr (inst_addr),
        .if_id     (if_id)
    );

    decode_stage decode_stage_inst (
        .clk      (clk),
        .rst      (rst),
        .if_id    (if_id),
        .redirect (redirect),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ex_fwd   (ex_fwd),
        .wb       (wb),
        .id_ex    (id_ex)
    );

    register_file register_file_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    execute_stage execute_stage_inst (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex),
        .ex_fwd   (ex_fwd),
        .wb       (wb),
        .redirect (redirect)
    );

endmodule

/* design/decode_stage.sv */
////////////////////////////////////////////////////////////
// decoder, operand forwarding and id/ex register
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module decode_stage import rv_core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  if_id_t                  if_id,
    input  redirect_t               redirect,
    output logic [`REG_ADDR_W-1:0]  rs1_addr,
    output logic [`REG_ADDR_W-1:0]  rs2_addr,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  wb_t                     ex_fwd,
    input  wb_t                     wb,
    output id_ex_t                  id_ex
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_b;
    alu_op_t                op;
    logic                   use_imm;
    logic                   is_alu;
    logic [`XLEN-1:0]       src1;
    logic [`XLEN-1:0]       src2;
    id_ex_t                 id_ex_next;

    // youngest producer first, then wb register, then the array
    function automatic logic [`XLEN-1:0] pick_src(
        input logic [`REG_ADDR_W-1:0] idx,
        input logic [`XLEN-1:0]       rf_data,
        input wb_t                    ex_res,
        input wb_t                    wb_res
    );
        logic [`XLEN-1:0] val;
        if (idx != '0 && ex_res.valid && ex_res.rd == idx) begin
            val = ex_res.data;
        end else if (idx != '0 && wb_res.valid && wb_res.rd == idx) begin
            val = wb_res.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign opcode   = if_id.inst[6:0];
    assign rd       = if_id.inst[11:7];
    assign funct3   = if_id.inst[14:12];
    assign rs1_addr = if_id.inst[19:15];
    assign rs2_addr = if_id.inst[24:20];
    assign funct7   = if_id.inst[31:25];

    assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
    assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
                    if_id.inst[30:25], if_id.inst[11:8], 1'b0};

    always_comb begin
        op      = OP_NOP;
        use_imm = 1'b0;
        case (opcode)
            `OPC_OP: begin
                case (funct3)
                    `F3_ADD_SUB: begin
                        if (funct7 == 7'd0) begin
                            op = OP_ADD;
                        end else if (funct7 == `F7_SUB) begin
                            op = OP_SUB;
                        end
                    end
                    `F3_SLT: op = (funct7 == 7'd0) ? OP_SLT : OP_NOP;
                    `F3_XOR: op = (funct7 == 7'd0) ? OP_XOR : OP_NOP;
                    `F3_OR:  op = (funct7 == 7'd0) ? OP_OR  : OP_NOP;
                    `F3_AND: op = (funct7 == 7'd0) ? OP_AND : OP_NOP;
                    default: op = OP_NOP;
                endcase
            end
            `OPC_OP_IMM: begin
                // only ADDI is supported
                if (funct3 == `F3_ADD_SUB) begin
                    op      = OP_ADD;
                    use_imm = 1'b1;
                end
            end
            `OPC_BRANCH: begin
                if (funct3 == `F3_BEQ) begin
                    op = OP_BEQ;
                end else if (funct3 == `F3_BNE) begin
                    op = OP_BNE;
                end
            end
            default: op = OP_NOP;
        endcase
    end

    assign is_alu = (op != OP_NOP) && (op != OP_BEQ) && (op != OP_BNE);

    assign src1 = pick_src(rs1_addr, rs1_data, ex_fwd, wb);
    assign src2 = pick_src(rs2_addr, rs2_data, ex_fwd, wb);

    always_comb begin
        id_ex_next.valid     = if_id.valid && !redirect.valid && (op != OP_NOP);
        id_ex_next.op        = op;
        id_ex_next.rd        = rd;
        id_ex_next.writes_rd = is_alu && (rd != '0);
        id_ex_next.op_a      = src1;
        id_ex_next.op_b      = use_imm ? imm_i : src2;
        id_ex_next.offset    = imm_b;
        id_ex_next.pc        = if_id.pc;
    end

    // flushed or undecodable slots enter execute as an all-zero bubble
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            id_ex <= '0;
        end else if (!id_ex_next.valid) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_next;
        end
    end

endmodule

/* design/execute_stage.sv */
////////////////////////////////////////////////////////////
// ALU, branch resolve and writeback register
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module execute_stage import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  id_ex_t    id_ex,
    output wb_t       ex_fwd,
    output wb_t       wb,
    output redirect_t redirect
);

    logic [`XLEN-1:0] result;
    logic             equal;
    logic             taken;

    always_comb begin
        case (id_ex.op)
            OP_ADD:  result = id_ex.op_a + id_ex.op_b;
            OP_SUB:  result = id_ex.op_a - id_ex.op_b;
            OP_AND:  result = id_ex.op_a & id_ex.op_b;
            OP_OR:   result = id_ex.op_a | id_ex.op_b;
            OP_XOR:  result = id_ex.op_a ^ id_ex.op_b;
            // signed compare
            OP_SLT:  result = {{(`XLEN-1){1'b0}},
                               ($signed(id_ex.op_a) < $signed(id_ex.op_b))};
            default: result = '0;
        endcase
    end

    assign equal = (id_ex.op_a == id_ex.op_b);
    assign taken = id_ex.valid &&
                   (((id_ex.op == OP_BEQ) && equal) || ((id_ex.op == OP_BNE) && !equal));

    assign redirect.valid  = taken;
    assign redirect.target = id_ex.pc + id_ex.offset;

    // result as seen by decode in the same cycle
    assign ex_fwd.valid = id_ex.valid && id_ex.writes_rd;
    assign ex_fwd.rd    = id_ex.rd;
    assign ex_fwd.data  = result;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb <= '0;
        end else begin
            wb <= ex_fwd;
        end
    end

endmodule

/* design/fetch_stage.sv */
////////////////////////////////////////////////////////////
// fetch stage with pc register and if/id register
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module fetch_stage import rv_core_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  redirect_t           redirect,
    input  logic [`INST_W-1:0]  inst_data,
    output logic [`XLEN-1:0]    inst_addr,
    output if_id_t              if_id
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_next;

    // taken branch wins over sequential fetch
    assign pc_next   = redirect.valid ? redirect.target : pc + `XLEN'd4;
    assign inst_addr = pc;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // the word fetched this cycle is on the wrong path when a redirect is present
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            if_id <= '0;
        end else begin
            if_id.valid <= !redirect.valid;
            if_id.pc    <= pc;
            if_id.inst  <= inst_data;
        end
    end

endmodule

/* design/register_file.sv */
////////////////////////////////////////////////////////////
// integer register file, two async reads, one write
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module register_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`REG_ADDR_W-1:0]  rs1_addr,
    input  logic [`REG_ADDR_W-1:0]  rs2_addr,
    output logic [`XLEN-1:0]        rs1_data,
    output logic [`XLEN-1:0]        rs2_data,
    input  rv_core_pkg::wb_t        wb
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 reads as zero whatever was written to it
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* design/rv_core_pkg.sv */
////////////////////////////////////////////////////////////
// operation enum and pipeline register structs
////////////////////////////////////////////////////////////
`include "rv_core_defines.svh"

package rv_core_pkg;

    // operation carried from decode into execute
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_BEQ,
        OP_BNE
    } alu_op_t;

    // fetch to decode
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [`INST_W-1:0] inst;
    } if_id_t;

    // decode to execute, operands already forwarded
    typedef struct packed {
        logic                   valid;
        alu_op_t                op;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   writes_rd;
        logic [`XLEN-1:0]       op_a;
        logic [`XLEN-1:0]       op_b;
        logic [`XLEN-1:0]       offset;
        logic [`XLEN-1:0]       pc;
    } id_ex_t;

    // register write, also used for forwarding
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

/* include/rv_core_defines.svh */
////////////////////////////////////////////////////////////
// widths, reset pc and RV32I field codes for the core
////////////////////////////////////////////////////////////
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

`define XLEN        32
`define INST_W      32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define RESET_PC    32'h0000_0000

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_BRANCH  7'b1100011

// funct3 codes
`define F3_ADD_SUB  3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

// funct7 for SUB
`define F7_SUB      7'b0100000

`endif

/* tb.f */
+incdir+include
design/rv_core_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/cpu_pipeline.sv
testbench/cpu_pipeline_props.sv
testbench/tb_cpu_pipeline.sv

/* testbench/cpu_pipeline_props.sv */
////////////////////////////////////////////////////////////
// concurrent assertions on pipeline top-level behavior
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module cpu_pipeline_props import rv_core_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic [`XLEN-1:0] inst_addr,
    input wb_t              wb,
    input redirect_t        redirect
);

    // quiet outputs while held in reset
    reset_quiet: assert property (@(posedge clk) !rst |-> !wb.valid && inst_addr == `RESET_PC)
        else $error("wb.valid or inst_addr wrong during reset");

    addr_aligned: assert property (@(posedge clk) disable iff (!rst) inst_addr[1:0] == 2'b00)
        else $error("inst_addr not word aligned");

    no_x0_write: assert property (@(posedge clk) disable iff (!rst) wb.valid |-> wb.rd != '0)
        else $error("writeback to x0");

    // sequential fetch when no branch is taken
    pc_step: assert property (@(posedge clk) disable iff (!rst)
        !redirect.valid |=> inst_addr == $past(inst_addr) + `XLEN'd4)
        else $error("pc did not advance by four");

endmodule

/* testbench/tb_cpu_pipeline.sv */
////////////////////////////////////////////////////////////
// cpu_pipeline testbench with program table, instruction
// memory model, expected writeback table and checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module tb_cpu_pipeline import rv_core_pkg::*; ();

    logic                   clk;
    logic                   rst;
    logic [`XLEN-1:0]       inst_addr;
    logic [`INST_W-1:0]     inst_data;
    wb_t                    wb;
    logic [`INST_W-1:0]     program_mem [$];
    logic [`REG_ADDR_W-1:0] exp_rd [$];
    logic [`XLEN-1:0]       exp_data [$];
    logic [`XLEN-1:0]       model_regs [`NUM_REGS];
    integer                 seed;
    int                     skip_count;
    int                     limit;
    int                     cycles;
    int                     idx;

    cpu_pipeline cpu_pipeline_inst (
        .clk       (clk),
        .rst       (rst),
        .inst_addr (inst_addr),
        .inst_data (inst_data),
        .wb        (wb)
    );

    bind cpu_pipeline cpu_pipeline_props props_inst (
        .clk       (clk),
        .rst       (rst),
        .inst_addr (inst_addr),
        .wb        (wb),
        .redirect  (redirect)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_rd(input logic [`REG_ADDR_W-1:0] got,
                            input logic [`REG_ADDR_W-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("FAILED: wb.rd = 0x%h, expected 0x%h (entry %0d)",
                               got, exp, idx));
    endtask

    task automatic check_data(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("FAILED: wb.data = 0x%h, expected 0x%h (entry %0d)",
                               got, exp, idx));
    endtask

    // appends one word; instructions in a taken branch's shadow are never modeled
    task automatic emit(input logic [31:0] word, input logic [4:0] rd, input logic [31:0] value);
        program_mem.push_back(word);
        if (skip_count > 0) begin
            skip_count--;
        end else if (rd != '0) begin
            model_regs[rd] = value;
            exp_rd.push_back(rd);
            exp_data.push_back(value);
        end
    endtask

    task automatic emit_alu(input alu_op_t op, input logic [4:0] rd, rs1, rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [6:0]  f7;
        logic [2:0]  f3;
        a  = model_regs[rs1];
        b  = model_regs[rs2];
        f7 = 7'd0;
        case (op)
            OP_SUB: begin
                f3  = `F3_ADD_SUB;
                f7  = `F7_SUB;
                val = a - b;
            end
            OP_AND: begin
                f3  = `F3_AND;
                val = a & b;
            end
            OP_OR: begin
                f3  = `F3_OR;
                val = a | b;
            end
            OP_XOR: begin
                f3  = `F3_XOR;
                val = a ^ b;
            end
            OP_SLT: begin
                f3  = `F3_SLT;
                val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            default: begin
                f3  = `F3_ADD_SUB;
                val = a + b;
            end
        endcase
        emit({f7, rs2, rs1, f3, rd, `OPC_OP}, rd, val);
    endtask

    task automatic emit_addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        emit({imm, rs1, `F3_ADD_SUB, rd, `OPC_OP_IMM}, rd,
             model_regs[rs1] + {{20{imm[11]}}, imm});
    endtask

    // offset of 12 lands on the third word after the branch
    task automatic emit_branch(input alu_op_t op, input logic [4:0] rs1, rs2);
        logic [12:0] off;
        logic        taken;
        logic        live;
        off   = 13'd12;
        taken = (op == OP_BEQ) == (model_regs[rs1] == model_regs[rs2]);
        live  = (skip_count == 0);
        emit({off[12], off[10:5], rs2, rs1, (op == OP_BEQ) ? `F3_BEQ : `F3_BNE,
              off[4:1], off[11], `OPC_BRANCH}, 5'd0, '0);
        if (live && taken)
            skip_count = 2;
    endtask

    task automatic build_program();
        logic [31:0] r;
        emit_addi(1, 0, 12'd5);
        emit_addi(2, 0, 12'hffd);
        emit_alu(OP_ADD, 3, 1, 2);
        emit_alu(OP_SUB, 4, 3, 1);
        emit_alu(OP_AND, 5, 4, 1);
        emit_alu(OP_OR,  6, 5, 2);
        emit_alu(OP_XOR, 7, 6, 3);
        emit_alu(OP_SLT, 8, 2, 1);
        emit_alu(OP_SLT, 9, 1, 2);
        // chained ADDI with negative random immediates
        for (int k = 0; k < 4; k++) begin
            r = $random(seed);
            emit_addi(5'(10 + k), (k == 0) ? 5'd1 : 5'(9 + k), r[11:0] | 12'h800);
        end
        emit_addi(0, 1, 12'd7);
        emit_alu(OP_OR, 14, 0, 1);
        emit_alu(OP_ADD, 0, 1, 2);
        emit(32'hffff_ffff, 5'd0, '0);
        emit({7'h01, 5'd2, 5'd1, `F3_ADD_SUB, 5'd27, `OPC_OP}, 5'd0, '0);
        emit_branch(OP_BEQ, 1, 1);
        emit_addi(15, 0, 12'd1);
        emit_addi(16, 0, 12'd2);
        emit_addi(17, 0, 12'd3);
        emit_branch(OP_BNE, 1, 2);
        emit_addi(15, 0, 12'd1);
        emit_addi(16, 0, 12'd2);
        emit_addi(18, 17, 12'd4);
        emit_branch(OP_BEQ, 1, 2);
        emit_addi(19, 0, 12'd9);
        emit_addi(20, 19, 12'd1);
        emit_alu(OP_ADD, 21, 20, 19);
        emit_branch(OP_BNE, 3, 3);
        emit_alu(OP_SUB, 22, 21, 20);
        emit_alu(OP_XOR, 23, 22, 1);
        emit_addi(24, 0, 12'd6);
        emit_branch(OP_BNE, 24, 0);
        emit_addi(15, 0, 12'd1);
        emit_addi(16, 0, 12'd2);
        emit_addi(25, 24, 12'hfff);
        // skipped words must have left x15 and x16 untouched
        emit_alu(OP_ADD, 26, 15, 16);
    endtask

    // words past the end are BEQ x0,x0,0
    function automatic logic [`INST_W-1:0] fetch_word(input logic [`XLEN-1:0] addr);
        if ((addr >> 2) < program_mem.size())
            return program_mem[addr >> 2];
        return 32'h0000_0063;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        inst_data = '0;
        forever begin
            @(posedge clk);
            #1 inst_data = fetch_word(inst_addr);
        end
    end

    initial begin
        rst        = 1'b1;
        seed       = 62;
        skip_count = 0;
        for (int i = 0; i < `NUM_REGS; i++)
            model_regs[i] = '0;
        build_program();
        limit = 4 * program_mem.size() + 20;
        #1 rst = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b1;
        idx    = 0;
        cycles = 0;
        while (idx < exp_rd.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_run($sformatf("writeback sequence did not finish within %0d cycles",
                                   limit));
            end else if (wb.valid) begin
                check_rd(wb.rd, exp_rd[idx]);
                check_data(wb.data, exp_data[idx]);
                idx++;
            end
        end
        repeat (10) begin
            @(negedge clk);
            if (wb.valid)
                fail_run("an extra writeback appeared after the last expected entry");
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
